// File: Bender.yml
package:
  name: mboot

sources:
  - verilog/wb_pkg.sv
  - verilog/mboot_pkg.sv
  - verilog/mboot_wb_slave.sv
  - verilog/mboot_regs.sv
  - verilog/mboot_top.sv
  - target: test
    files:
      - verif/mboot_models.sv
      - verif/mboot_tb.sv

// File: list.f
verilog/wb_pkg.sv
verilog/mboot_pkg.sv
verilog/mboot_wb_slave.sv
verilog/mboot_regs.sv
verilog/mboot_top.sv
verif/mboot_models.sv
verif/mboot_tb.sv

// File: verif/mboot_models.sv
`timescale 1ns/10ps

// stands in for the vendor ICAP primitive, only the write path is modeled
module icap_model
	import mboot_pkg::*;
(
	input  logic       RST_I,
	input  icap_ctrl_s icap_ctrl,
	output icap_stat_s icap_stat,
	output int         words      // configuration words taken so far
);

	logic icap_clk;

	assign icap_clk = icap_ctrl.clk;

	// a write cycle is ce and write both low at a rising icap clock
	always_ff @(posedge icap_clk or posedge RST_I) begin
		if (RST_I) begin
			icap_stat.busy <= 1'b0;
			icap_stat.o    <= 16'h0000;
		end else if (!icap_ctrl.ce && !icap_ctrl.write) begin
			icap_stat.busy <= 1'b1;
			icap_stat.o    <= icap_ctrl.i; // echoed back so software can see what arrived
		end else begin
			icap_stat.busy <= 1'b0;        // one idle clock finishes the word
		end
	end

	always_ff @(posedge icap_clk or posedge RST_I) begin
		if (RST_I)
			words <= 0;
		else if (!icap_ctrl.ce && !icap_ctrl.write)
			words <= words + 1;
	end

endmodule

// data out of the SPI flash
// it follows the level that the test asks for on the next system clock
module miso_driver (
	input  logic CLK_I,
	input  logic RST_I,
	input  logic level,
	output logic miso
);

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			miso <= 1'b0;
		else
			miso <= level;
	end

endmodule

// File: verif/mboot_tb.sv
`timescale 1ns/10ps

module mboot_tb
	import wb_pkg::*;
	import mboot_pkg::*;
();

	localparam int ack_timeout = 20;          // cycles a transfer may wait for ack
	localparam logic [23:0] exp_id = 24'h123456;

	logic        CLK_I;
	logic        RST_I;
	wb_req_s     bus_req;
	wb_rsp_s     bus_rsp;
	flash_pins_s flash;
	logic        miso;
	logic        miso_level; // what the flash should send back next
	icap_ctrl_s  icap_ctrl;
	icap_stat_s  icap_stat;
	int          icap_words;

	int    seed;
	int    err_count;
	int    test_count;
	int    fail_count;
	int    err_at_start;
	string cur_test;

	always #5 CLK_I = ~CLK_I;

	mboot_top dut0 (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.bus_req   (bus_req),
		.bus_rsp   (bus_rsp),
		.flash     (flash),
		.miso      (miso),
		.icap_ctrl (icap_ctrl),
		.icap_stat (icap_stat)
	);

	icap_model icap0 (
		.RST_I     (RST_I),
		.icap_ctrl (icap_ctrl),
		.icap_stat (icap_stat),
		.words     (icap_words)
	);

	miso_driver miso0 (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.level (miso_level),
		.miso  (miso)
	);

	// the ICAP wants every byte mirrored, bit 7 of a byte lands on bit 0
	function automatic logic [15:0] flip_within_bytes(input logic [15:0] d);
		logic [15:0] r;
		for (int k = 0; k < 16; k++)
			r[k] = d[(k / 8) * 8 + 7 - (k % 8)];
		return r;
	endfunction

	task automatic check_word(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("error in %s: %s expected %h actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test     = name;
		err_at_start = err_count;
		test_count++;
	endtask

	task automatic end_test();
		if (err_count == err_at_start) begin
			$display("%s: done, no errors", cur_test);
		end else begin
			fail_count++;
			$display("%s: done, %0d errors", cur_test, err_count - err_at_start);
		end
	endtask

	task automatic wait_for_ack(output bit seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < ack_timeout) begin
			@(negedge CLK_I);
			seen = bus_rsp.ack;
			n++;
		end
	endtask

	// one classic cycle, the request is held until ack and dropped right after it
	task automatic bus_transfer(input logic we, input logic [wb_adr_w-1:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
		bit seen;
		rdat = '0;
		@(posedge CLK_I);
		bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		wait_for_ack(seen);
		if (!seen) begin
			$display("%s: ack never came for the access to address %h", cur_test, adr);
			err_count++;
		end else begin
			rdat = bus_rsp.dat;
		end
		@(posedge CLK_I);
		bus_req <= '0;
		if (seen) begin
			@(negedge CLK_I);
			assert (!bus_rsp.ack) else begin
				$display("%s: ack stayed high for more than one cycle at address %h",
					cur_test, adr);
				err_count++;
			end
		end
	endtask

	task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_transfer(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [31:0] dat);
		bus_transfer(1'b0, adr, 32'h0, dat);
	endtask

	task automatic test_reset_values();
		logic [31:0] rd;
		flash_pins_s exp_pins;
		icap_ctrl_s  exp_ctrl;
		start_test("reset_values");
		exp_pins = '{sck: 1'b0, cs: 1'b1, mosi: 1'b0, hold_n: 1'b1, wp_n: 1'b1};
		exp_ctrl = '{clk: 1'b1, ce: 1'b1, write: 1'b0, i: 16'h0000};
		@(negedge CLK_I);
		check_word("flash port", exp_pins, flash);
		check_word("icap_ctrl port", exp_ctrl, icap_ctrl);
		wb_read(mboot_flash_adr, rd);
		check_word("flash register", {exp_id, 2'b00, miso_level, exp_pins}, rd);
		wb_read(mboot_icapo_adr, rd);
		check_word("icap register", {13'd0, exp_ctrl}, rd);
		end_test();
	endtask

	task automatic test_flash_pins();
		logic [31:0] wd;
		logic [31:0] rd;
		logic        bit_in;
		start_test("flash_pins");
		for (int n = 0; n < 6; n++) begin
			wd     = $random(seed);   // upper bits are junk, only the pins are stored
			bit_in = wd[31];
			@(posedge CLK_I);
			miso_level <= bit_in;
			wb_write(mboot_flash_adr, wd);
			check_word("flash port", wd[4:0], flash);
			wb_read(mboot_flash_adr, rd);
			check_word("flash register", {exp_id, 2'b00, bit_in, wd[4:0]}, rd);
		end
		end_test();
	endtask

	task automatic test_icap_readback();
		logic [31:0] wd;
		logic [31:0] rd;
		icap_ctrl_s  exp_port;
		start_test("icap_readback");
		for (int n = 0; n < 4; n++) begin
			wd         = $random(seed);
			exp_port   = wd[18:0];
			exp_port.i = flip_within_bytes(wd[15:0]);
			wb_write(mboot_icapo_adr, wd);
			check_word("icap_ctrl port", exp_port, icap_ctrl);
			wb_read(mboot_icapo_adr, rd);
			check_word("icap register", {13'd0, wd[18:0]}, rd);
		end
		end_test();
	endtask

	task automatic test_icap_bitbang();
		logic [15:0] word;
		logic [31:0] rd;
		icap_ctrl_s  ctrl;
		int          words_before;
		start_test("icap_bitbang");
		for (int n = 0; n < 2; n++) begin
			word         = $random(seed);
			words_before = icap_words;
			ctrl         = '{clk: 1'b0, ce: 1'b0, write: 1'b0, i: word};
			wb_write(mboot_icapo_adr, ctrl);
			ctrl.clk = 1'b1;                  // rising icap clock takes the word
			wb_write(mboot_icapo_adr, ctrl);
			wb_read(mboot_icapi_adr, rd);
			check_word("status while busy", {15'd0, 1'b1, flip_within_bytes(word)}, rd);
			check_word("icap words taken", words_before + 1, icap_words);
			ctrl = '{clk: 1'b0, ce: 1'b1, write: 1'b0, i: word};
			wb_write(mboot_icapo_adr, ctrl);
			ctrl.clk = 1'b1;
			wb_write(mboot_icapo_adr, ctrl);
			wb_read(mboot_icapi_adr, rd);
			check_word("status after idle clock", {15'd0, 1'b0, flip_within_bytes(word)}, rd);
		end
		end_test();
	endtask

	task automatic test_unmapped();
		logic [wb_adr_w-1:0] holes [3];
		logic [31:0]         wd;
		logic [31:0]         rd;
		flash_pins_s         pins_set;
		icap_ctrl_s          ctrl_set;
		icap_ctrl_s          exp_port;
		start_test("unmapped");
		holes = '{6'h0c, 6'h10, 6'h3c};
		// known contents in both registers, so that any stray write shows up
		wd       = $random(seed);
		pins_set = wd[4:0];
		wd       = $random(seed);
		ctrl_set = wd[18:0];
		wb_write(mboot_flash_adr, pins_set);
		wb_write(mboot_icapo_adr, ctrl_set);
		exp_port   = ctrl_set;
		exp_port.i = flip_within_bytes(ctrl_set.i);
		for (int n = 0; n < 3; n++) begin
			wd = $random(seed);
			wb_write(holes[n], wd);
			wb_read(holes[n], rd);
			check_word("unmapped read", 32'h0, rd);
		end
		check_word("flash port", pins_set, flash);
		check_word("icap_ctrl port", exp_port, icap_ctrl);
		wb_read(mboot_flash_adr, rd);
		check_word("flash register", {exp_id, 2'b00, miso_level, pins_set}, rd);
		wb_read(mboot_icapo_adr, rd);
		check_word("icap register", {13'd0, ctrl_set}, rd);
		end_test();
	endtask

	initial begin
		seed       = 49082;
		err_count  = 0;
		test_count = 0;
		fail_count = 0;
		CLK_I      = 1'b0;
		RST_I      = 1'b1;
		bus_req    = '0;
		miso_level = 1'b0;
		repeat (16) @(posedge CLK_I);
		RST_I <= 1'b0;
		@(posedge CLK_I);

		test_reset_values();
		test_flash_pins();
		test_icap_readback();
		test_icap_bitbang();
		test_unmapped();

		$display("tests run %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
		if (err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: verilog/mboot_pkg.sv
package mboot_pkg;

	// register map, byte addresses as software sees them
	localparam logic [wb_pkg::wb_adr_w-1:0] mboot_flash_adr = 6'h0;
	localparam logic [wb_pkg::wb_adr_w-1:0] mboot_icapo_adr = 6'h4;
	localparam logic [wb_pkg::wb_adr_w-1:0] mboot_icapi_adr = 6'h8; // read only

	// lets software check that it talks to the multiboot block
	localparam logic [23:0] mboot_id = 24'h123456;

	// SPI configuration flash pins, driven straight from the register
	typedef struct packed {
		logic sck;
		logic cs;     // active low chip select
		logic mosi;
		logic hold_n;
		logic wp_n;
	} flash_pins_s;

	// flash deselected, hold and write protect inactive
	localparam flash_pins_s flash_pins_rst = '{sck: 1'b0, cs: 1'b1, mosi: 1'b0,
		hold_n: 1'b1, wp_n: 1'b1};

	typedef struct packed {
		logic        clk;
		logic        ce;    // active low
		logic        write; // low selects a write cycle
		logic [15:0] i;
	} icap_ctrl_s;

	// ICAP idle with its clock parked high
	localparam icap_ctrl_s icap_ctrl_rst = '{clk: 1'b1, ce: 1'b1, write: 1'b0, i: 16'h0000};

	typedef struct packed {
		logic        busy;
		logic [15:0] o;
	} icap_stat_s;

	// one bus word, seen through the layout of whichever register it belongs to
	typedef union packed {
		struct packed {
			logic [23:0] id;
			logic [1:0]  pad;
			logic        miso;
			flash_pins_s pins;
		} flash;
		struct packed {
			logic [12:0] pad;
			icap_ctrl_s  ctrl;
		} icap_ctrl;
		struct packed {
			logic [14:0] pad;
			icap_stat_s  stat;
		} icap_stat;
	} mboot_word_u;

	// one strobe per register and direction, at most one set at a time
	typedef struct packed {
		logic flash_wr;
		logic flash_rd;
		logic icap_wr;
		logic icap_rd;
		logic stat_rd;
	} mboot_access_s;

endpackage

// File: verilog/mboot_regs.sv
`timescale 1ns/10ps

module mboot_regs
	import mboot_pkg::*;
(
	input  logic          CLK_I,
	input  logic          RST_I,
	input  mboot_access_s access,
	input  mboot_word_u   wdat,
	output mboot_word_u   rdat,
	input  logic          miso,
	input  icap_stat_s    icap_stat,
	output flash_pins_s   flash,
	output icap_ctrl_s    icap_ctrl
);

	icap_ctrl_s  icap_q;  // control word as software wrote it
	mboot_word_u rd_next;

	// the ICAP port takes each byte with bit 0 in the msb position,
	// while configuration words in the bitstream are written msb first
	function automatic logic [15:0] icap_swap(input logic [15:0] d);
		logic [15:0] s;
		for (int b = 0; b < 8; b++) begin
			s[b]     = d[7-b];
			s[8 + b] = d[15-b];
		end
		return s;
	endfunction

	// flash pins are bit-banged by software, one register write per edge of sck
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			flash <= flash_pins_rst;
		else if (access.flash_wr)
			flash <= wdat.flash.pins;
	end

	// same for the ICAP, clk is toggled by two writes to this register
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			icap_q <= icap_ctrl_rst;
		else if (access.icap_wr)
			icap_q <= wdat.icap_ctrl.ctrl;
	end

	always_comb begin
		icap_ctrl   = icap_q;
		icap_ctrl.i = icap_swap(icap_q.i); // only the data lines change order
	end

	// read mux, the zero default also covers unmapped addresses
	always_comb begin
		rd_next = '0;
		if (access.flash_rd) begin
			rd_next.flash.id   = mboot_id;
			rd_next.flash.miso = miso;   // sampled live, software clocks it in itself
			rd_next.flash.pins = flash;
		end else if (access.icap_rd) begin
			rd_next.icap_ctrl.ctrl = icap_q;   // readback in software bit order
		end else if (access.stat_rd) begin
			rd_next.icap_stat.stat = icap_stat;
		end
	end

	// lands at the edge that raises ack, so it is valid during the ack cycle
	always_ff @(posedge CLK_I) begin
		rdat <= rd_next;
	end

	// a write to one register must never disturb the other one
	flash_hold_a: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		!access.flash_wr |=> $stable(flash)
	) else $error("flash pins changed without a write to the flash register");

	icap_hold_a: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		!access.icap_wr |=> $stable(icap_q)
	) else $error("ICAP control changed without a write to the ICAP register");

endmodule

// File: verilog/mboot_top.sv
`timescale 1ns/10ps

module mboot_top
	import wb_pkg::*;
	import mboot_pkg::*;
(
	input  logic        CLK_I,
	input  logic        RST_I,
	input  wb_req_s     bus_req,
	output wb_rsp_s     bus_rsp,
	output flash_pins_s flash,
	input  logic        miso,
	output icap_ctrl_s  icap_ctrl,   // data already in ICAP bit order
	input  icap_stat_s  icap_stat
);

	logic          ack;
	mboot_access_s access;  // one-hot strobe, valid in the cycle before ack
	mboot_word_u   wdat;
	mboot_word_u   rdat;

	assign wdat    = bus_req.dat;
	assign bus_rsp = '{ack: ack, dat: rdat};

	mboot_wb_slave slave0 (
		.CLK_I   (CLK_I),
		.RST_I   (RST_I),
		.bus_req (bus_req),
		.ack     (ack),
		.access  (access)
	);

	mboot_regs regs0 (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.access    (access),
		.wdat      (wdat),
		.rdat      (rdat),
		.miso      (miso),
		.icap_stat (icap_stat),
		.flash     (flash),
		.icap_ctrl (icap_ctrl)
	);

endmodule

// File: verilog/mboot_wb_slave.sv
`timescale 1ns/10ps

module mboot_wb_slave
	import wb_pkg::*;
	import mboot_pkg::*;
(
	input  logic          CLK_I,
	input  logic          RST_I,
	input  wb_req_s       bus_req,
	output logic          ack,
	output mboot_access_s access
);

	logic req_new;   // a cycle that has not been acknowledged yet
	logic req_wr;
	logic req_rd;
	logic hit_flash;
	logic hit_icap;
	logic hit_stat;

	// while ack is high the master still shows the old request, so it must not count twice
	assign req_new = bus_req.cyc & bus_req.stb & ~ack;
	assign req_wr  = req_new & bus_req.we;
	assign req_rd  = req_new & ~bus_req.we;

	assign hit_flash = (bus_req.adr == mboot_flash_adr);
	assign hit_icap  = (bus_req.adr == mboot_icapo_adr);
	assign hit_stat  = (bus_req.adr == mboot_icapi_adr);

	// no wait states, every request is answered at the next edge
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			ack <= 1'b0;
		else
			ack <= req_new;
	end

	// unmapped addresses and writes to the status word leave all strobes low
	// but still get their ack above
	always_comb begin
		access          = '0;
		access.flash_wr = req_wr & hit_flash;
		access.flash_rd = req_rd & hit_flash;
		access.icap_wr  = req_wr & hit_icap;
		access.icap_rd  = req_rd & hit_icap;
		access.stat_rd  = req_rd & hit_stat; // status is read only
	end

	// a master that keeps stb high still sees ack drop between transfers
	ack_single_a: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		ack |=> !ack
	) else $error("ack held high for more than one cycle");

	ack_onehot_a: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		$onehot0(access)
	) else $error("more than one register selected: %b", access);

endmodule

// File: verilog/wb_pkg.sv
package wb_pkg;

	// the multiboot block only decodes word addresses 0x0, 0x4 and 0x8
	localparam int wb_adr_w = 6;
	localparam int wb_dat_w = 32;

	// master to slave, held stable by the master until ack
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [wb_adr_w-1:0] adr;
		logic [wb_dat_w-1:0] dat;
	} wb_req_s;

	// slave to master
	typedef struct packed {
		logic                ack; // one cycle per transfer
		logic [wb_dat_w-1:0] dat; // read data, valid while ack is high
	} wb_rsp_s;

endpackage
